//--- sim/mem_cases.txt
# op addr data strb resp exp, all fields after the op letter in hex
# W data write, R data read, I instr read; exp is print byte, exit value or error read data
W 00000000 11223344 f 0 00000000
W 00000004 a5a5a5a5 f 0 00000000
W 00000004 00c30000 4 0 00000000
W 00000004 0000007e 1 0 00000000
W 00000ffc deadbeef f 0 00000000
W 00000ffc 00123400 6 0 00000000
W 00000100 cafef00d f 0 00000000
R 00000000 00000000 0 0 00000000
R 00000004 00000000 0 0 00000000
R 00000ffc 00000000 0 0 00000000
I 00000004 00000000 0 0 00000000
I 00000ffc 00000000 0 0 00000000
I 00000100 00000000 0 0 00000000
W 10000000 00000441 1 0 00000041
W 20000004 0000002a f 0 0000002a
W 20000010 12345678 f 0 00000000
W 00001000 ffffffff f 2 00000000
W 10000004 ffffffff f 2 00000000
R 00001000 00000000 0 2 00000000
R 10000000 00000000 0 2 00000000
R 20000004 00000000 0 2 00000000
I 00001008 00000000 0 2 00000000
R 00000000 00000000 0 0 00000000
I 00000004 00000000 0 0 00000000
W 00000008 0bad0bad 9 0 00000000
R 00000008 00000000 0 0 00000000

//--- filelist.f
common/mem_pkg.sv
common/ram_port_if.sv
ram/dp_byte_ram.sv
axil/axil_instr_ctrl.sv
axil/axil_data_ctrl.sv
source/mem_top.sv
sim/tb_mem_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_mem_top -o tb_mem_top
./obj_dir/tb_mem_top | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"

//--- sim/tb_mem_top.sv
module tb_mem_top
  import mem_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 2;
  localparam int CASE_CYCLES  = 20;  // cycle budget per case covering the longest stall

  logic      clk_i;
  logic      rst_n_i;
  addr_t     instr_ar_addr_i;
  logic      instr_ar_valid_i;
  logic      instr_ar_ready_o;
  word_t     instr_r_data_o;
  axi_resp_e instr_r_resp_o;
  logic      instr_r_valid_o;
  logic      instr_r_ready_i;
  addr_t     data_aw_addr_i;
  logic      data_aw_valid_i;
  logic      data_aw_ready_o;
  word_t     data_w_data_i;
  strb_t     data_w_strb_i;
  logic      data_w_valid_i;
  logic      data_w_ready_o;
  axi_resp_e data_b_resp_o;
  logic      data_b_valid_o;
  logic      data_b_ready_i;
  addr_t     data_ar_addr_i;
  logic      data_ar_valid_i;
  logic      data_ar_ready_o;
  word_t     data_r_data_o;
  axi_resp_e data_r_resp_o;
  logic      data_r_valid_o;
  logic      data_r_ready_i;
  byte_t     print_data_o;
  logic      print_valid_o;
  word_t     exit_value_o;
  logic      exit_valid_o;

  int        errors;
  integer    seed;                  // back-pressure delays
  int        n_cases;
  logic      cases_loaded;
  word_t     model [2**RAM_IDX_W];  // reference copy of the ram

  logic [7:0] op_q   [$];           // case queues with one entry per file line
  addr_t      addr_q [$];
  word_t      data_q [$];
  strb_t      strb_q [$];
  axi_resp_e  resp_q [$];
  word_t      exp_q  [$];

  mem_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic check_data(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s data %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s resp %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_print(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s print byte %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_exit(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s exit value %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report(input string text);
    $display("Error at %0t: %s", $time, text);
    errors++;
  endtask

  // ------------------------------------------------------------------------
  // read channels of both ports
  // ------------------------------------------------------------------------
  task automatic drive_ar(input logic instr, input logic valid, input addr_t addr);
    if (instr) begin
      instr_ar_valid_i = valid;
      instr_ar_addr_i  = addr;
    end else begin
      data_ar_valid_i = valid;
      data_ar_addr_i  = addr;
    end
  endtask

  task automatic sample_r(input logic instr, output logic valid, output word_t data,
                          output axi_resp_e resp, output logic ar_ready);
    valid    = instr ? instr_r_valid_o : data_r_valid_o;
    data     = instr ? instr_r_data_o : data_r_data_o;
    resp     = instr ? instr_r_resp_o : data_r_resp_o;
    ar_ready = instr ? instr_ar_ready_o : data_ar_ready_o;
  endtask

  task automatic do_read(input logic instr, input addr_t addr, input axi_resp_e exp_resp,
                         input word_t exp_data, input string what);
    logic      valid;
    logic      ready;
    word_t     data;
    word_t     held_data;
    axi_resp_e resp;
    axi_resp_e held_resp;
    int        stall;
    @(negedge clk_i);
    drive_ar(instr, 1'b1, addr);
    ready = 1'b0;
    while (!ready) begin
      #1;                                   // ready settles after the drive
      sample_r(instr, valid, data, resp, ready);
      if (!ready) @(negedge clk_i);
    end
    @(negedge clk_i);                       // address taken on the last edge
    drive_ar(instr, 1'b0, '0);
    #1;
    sample_r(instr, valid, held_data, held_resp, ready);
    while (!valid) begin
      @(negedge clk_i);
      #1;
      sample_r(instr, valid, held_data, held_resp, ready);
    end
    check_resp(held_resp, exp_resp, what);
    check_data(held_data, exp_data, what);
    stall = $random(seed) & 7;
    repeat (stall) begin
      @(negedge clk_i);
      #1;
      sample_r(instr, valid, data, resp, ready);
      if (!valid) report({what, ": read valid dropped before the handshake"});
      if (ready) report({what, ": new read address accepted while a response is stalled"});
      check_data(data, held_data, {what, " stalled"});
      check_resp(resp, held_resp, {what, " stalled"});
    end
    @(negedge clk_i);
    if (instr) instr_r_ready_i = 1'b1;
    else data_r_ready_i = 1'b1;
    #1;
    sample_r(instr, valid, data, resp, ready);
    if (!valid) report({what, ": read valid dropped before the handshake"});
    if (ready) report({what, ": new read address accepted while a response is stalled"});
    check_data(data, held_data, {what, " at the handshake"});
    check_resp(resp, held_resp, {what, " at the handshake"});
    @(negedge clk_i);
    instr_r_ready_i = 1'b0;
    data_r_ready_i  = 1'b0;
    #1;
    sample_r(instr, valid, data, resp, ready);
    if (valid) report({what, ": read valid still high after the handshake"});
  endtask

  // ------------------------------------------------------------------------
  // write channels and control pulses
  // ------------------------------------------------------------------------
  task automatic do_write(input addr_t addr, input word_t data, input strb_t strb,
                          input axi_resp_e exp_resp, input word_t exp_val, input string what);
    logic      is_print;
    logic      is_exit;
    axi_resp_e held_resp;
    int        stall;
    is_print = (addr == PRINT_ADDR);
    is_exit  = (addr == EXIT_VALUE_ADDR) || (addr == EXIT_ZERO_ADDR);
    @(negedge clk_i);
    data_aw_addr_i  = addr;
    data_aw_valid_i = 1'b1;
    data_w_data_i   = data;
    data_w_strb_i   = strb;
    data_w_valid_i  = 1'b1;
    #1;
    while (!(data_aw_ready_o && data_w_ready_o)) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    data_aw_valid_i = 1'b0;
    data_w_valid_i  = 1'b0;
    #1;
    // pulses belong to the first cycle after the transfer
    if (print_valid_o !== is_print) report({what, ": print valid wrong after the transfer"});
    if (exit_valid_o !== is_exit) report({what, ": exit valid wrong after the transfer"});
    if (is_print) check_print(print_data_o, exp_val[7:0], what);
    if (is_exit) check_exit(exit_value_o, exp_val, what);
    if (data_b_valid_o !== 1'b1) report({what, ": write response missing after the transfer"});
    held_resp = data_b_resp_o;
    check_resp(held_resp, exp_resp, what);
    stall = $random(seed) & 7;
    repeat (stall) begin
      @(negedge clk_i);
      #1;
      if (print_valid_o || exit_valid_o) report({what, ": control pulse longer than a cycle"});
      if (!data_b_valid_o) report({what, ": write response dropped before the handshake"});
      check_resp(data_b_resp_o, held_resp, {what, " stalled"});
    end
    @(negedge clk_i);
    data_b_ready_i = 1'b1;
    #1;
    if (print_valid_o || exit_valid_o) report({what, ": control pulse longer than a cycle"});
    if (!data_b_valid_o) report({what, ": write response dropped before the handshake"});
    check_resp(data_b_resp_o, held_resp, {what, " at the handshake"});
    @(negedge clk_i);
    data_b_ready_i = 1'b0;
    #1;
    if (data_b_valid_o) report({what, ": write response still valid after the handshake"});
  endtask

  task automatic load_cases();
    integer                fd;
    integer                n;
    logic [63:0]           tok;
    logic [8*128-1:0]      line_buf;
    addr_t                 a;
    word_t                 d;
    strb_t                 s;
    logic [1:0]            r;
    word_t                 e;
    fd = $fopen("sim/mem_cases.txt", "r");
    if (fd == 0) begin
      report("could not open sim/mem_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      tok = '0;
      n = $fscanf(fd, "%s", tok);
      if (n != 1) break;
      if (tok == "#") begin
        n = $fgets(line_buf, fd);         // skip the rest of a comment line
      end else begin
        n = $fscanf(fd, "%h %h %h %h %h", a, d, s, r, e);
        if (n != 5) begin
          report("malformed line in the cases file");
          break;
        end
        op_q.push_back(tok[7:0]);
        addr_q.push_back(a);
        data_q.push_back(d);
        strb_q.push_back(s);
        resp_q.push_back(axi_resp_e'(r));
        exp_q.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input int k);
    string    what;
    ram_idx_t idx;
    word_t    exp_data;
    what     = $sformatf("case %0d %c %h", k, op_q[k], addr_q[k]);
    idx      = addr_q[k][RAM_IDX_W+1:2];
    exp_data = (resp_q[k] == RESP_OKAY) ? model[idx] : exp_q[k];  // error reads return the file value
    case (op_q[k])
      "W": begin
        do_write(addr_q[k], data_q[k], strb_q[k], resp_q[k], exp_q[k], what);
        if (addr_q[k] < RAM_BYTES) begin
          for (int i = 0; i < STRB_W; i++) begin
            if (strb_q[k][i]) model[idx][i*8 +: 8] = data_q[k][i*8 +: 8];
          end
        end
      end
      "R":     do_read(1'b0, addr_q[k], resp_q[k], exp_data, what);
      "I":     do_read(1'b1, addr_q[k], resp_q[k], exp_data, what);
      default: report({what, ": unknown operation in the cases file"});
    endcase
  endtask

  // ------------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------------
  initial begin
    errors           = 0;
    seed             = 29664;
    cases_loaded     = 1'b0;
    rst_n_i          = 1'b0;
    instr_ar_addr_i  = '0;
    instr_ar_valid_i = 1'b0;
    instr_r_ready_i  = 1'b0;
    data_aw_addr_i   = '0;
    data_aw_valid_i  = 1'b0;
    data_w_data_i    = '0;
    data_w_strb_i    = '0;
    data_w_valid_i   = 1'b0;
    data_b_ready_i   = 1'b0;
    data_ar_addr_i   = '0;
    data_ar_valid_i  = 1'b0;
    data_r_ready_i   = 1'b0;
    load_cases();
    n_cases = op_q.size();
    if (n_cases == 0) report("no cases were read");
    cases_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int k = 0; k < n_cases; k++) begin
      run_case(k);
    end
    repeat (2) @(negedge clk_i);
    $display("%0d errors in %0d cases", errors, n_cases);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    time limit;
    wait (cases_loaded);
    limit = (n_cases * CASE_CYCLES + RESET_CYCLES + 2) * CLK_PERIOD;
    #(limit);
    report("the run timed out before all cases finished");
    $display("%0d errors in %0d cases", errors, n_cases);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- source/mem_top.sv
module mem_top
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  // ------------------------------------------------------------------------
  // instruction port, read only
  // ------------------------------------------------------------------------
  input  addr_t     instr_ar_addr_i,
  input  logic      instr_ar_valid_i,
  output logic      instr_ar_ready_o,
  output word_t     instr_r_data_o,
  output axi_resp_e instr_r_resp_o,
  output logic      instr_r_valid_o,
  input  logic      instr_r_ready_i,

  // ------------------------------------------------------------------------
  // data port, read and write
  // ------------------------------------------------------------------------
  input  addr_t     data_aw_addr_i,
  input  logic      data_aw_valid_i,
  output logic      data_aw_ready_o,
  input  word_t     data_w_data_i,
  input  strb_t     data_w_strb_i,
  input  logic      data_w_valid_i,
  output logic      data_w_ready_o,
  output axi_resp_e data_b_resp_o,
  output logic      data_b_valid_o,
  input  logic      data_b_ready_i,
  input  addr_t     data_ar_addr_i,
  input  logic      data_ar_valid_i,
  output logic      data_ar_ready_o,
  output word_t     data_r_data_o,
  output axi_resp_e data_r_resp_o,
  output logic      data_r_valid_o,
  input  logic      data_r_ready_i,

  // simulation control
  output byte_t     print_data_o,
  output logic      print_valid_o,
  output word_t     exit_value_o,
  output logic      exit_valid_o
);

  ram_port_if port_a ();  // instruction side of the ram
  ram_port_if port_b ();  // data side of the ram

  axil_instr_ctrl u_instr (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_addr_i  (instr_ar_addr_i),
    .ar_valid_i (instr_ar_valid_i),
    .ar_ready_o (instr_ar_ready_o),
    .r_data_o   (instr_r_data_o),
    .r_resp_o   (instr_r_resp_o),
    .r_valid_o  (instr_r_valid_o),
    .r_ready_i  (instr_r_ready_i),
    .ram_o      (port_a.ctrl)
  );

  axil_data_ctrl u_data (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .aw_addr_i     (data_aw_addr_i),
    .aw_valid_i    (data_aw_valid_i),
    .aw_ready_o    (data_aw_ready_o),
    .w_data_i      (data_w_data_i),
    .w_strb_i      (data_w_strb_i),
    .w_valid_i     (data_w_valid_i),
    .w_ready_o     (data_w_ready_o),
    .b_resp_o      (data_b_resp_o),
    .b_valid_o     (data_b_valid_o),
    .b_ready_i     (data_b_ready_i),
    .ar_addr_i     (data_ar_addr_i),
    .ar_valid_i    (data_ar_valid_i),
    .ar_ready_o    (data_ar_ready_o),
    .r_data_o      (data_r_data_o),
    .r_resp_o      (data_r_resp_o),
    .r_valid_o     (data_r_valid_o),
    .r_ready_i     (data_r_ready_i),
    .print_data_o  (print_data_o),
    .print_valid_o (print_valid_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o),
    .ram_o         (port_b.ctrl)
  );

  dp_byte_ram u_ram (
    .clk_i    (clk_i),
    .port_a_i (port_a.ram),
    .port_b_i (port_b.ram)
  );

endmodule

//--- axil/axil_data_ctrl.sv
module axil_data_ctrl
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  // write address, data and response
  input  addr_t     aw_addr_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  word_t     w_data_i,
  input  strb_t     w_strb_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output axi_resp_e b_resp_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,

  // read address and data
  input  addr_t     ar_addr_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output word_t     r_data_o,
  output axi_resp_e r_resp_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,

  // simulation control pulses
  output byte_t     print_data_o,
  output logic      print_valid_o,
  output word_t     exit_value_o,
  output logic      exit_valid_o,

  ram_port_if.ctrl  ram_o
);

  typedef enum logic [2:0] {
    TGT_RAM,
    TGT_PRINT,
    TGT_EXIT_VAL,
    TGT_EXIT_ZERO,
    TGT_ERR
  } wr_tgt_e;

  wr_tgt_e wr_tgt;       // decoded write target
  logic    wr_accept;    // aw and w transfer together
  logic    b_valid_q;
  logic    b_err_q;
  logic    ar_ready_q;
  logic    ar_fire;
  logic    rd_in_range;
  logic    rd_busy_q;    // ram read in flight
  logic    r_valid_q;
  logic    rd_err_q;
  word_t   r_data_q;
  logic    print_valid_q;
  byte_t   print_data_q;
  logic    exit_valid_q;
  word_t   exit_value_q;

  // ------------------------------------------------------------------------
  // write decode and accept
  // ------------------------------------------------------------------------
  always_comb begin
    if (aw_addr_i < RAM_BYTES) begin
      wr_tgt = TGT_RAM;
    end else if (aw_addr_i == PRINT_ADDR) begin
      wr_tgt = TGT_PRINT;
    end else if (aw_addr_i == EXIT_VALUE_ADDR) begin
      wr_tgt = TGT_EXIT_VAL;
    end else if (aw_addr_i == EXIT_ZERO_ADDR) begin
      wr_tgt = TGT_EXIT_ZERO;
    end else begin
      wr_tgt = TGT_ERR;         // unmapped, dropped with slverr
    end
  end

  assign wr_accept  = aw_valid_i && w_valid_i && !b_valid_q;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;

  // reads only get the port when no write is taking it
  assign ar_ready_o  = ar_ready_q && !wr_accept;
  assign ar_fire     = ar_valid_i && ar_ready_o;
  assign rd_in_range = (ar_addr_i < RAM_BYTES);  // control regs read as slverr

  // ------------------------------------------------------------------------
  // ram port b mux, write first
  // ------------------------------------------------------------------------
  assign ram_o.en    = wr_accept ? (wr_tgt == TGT_RAM) : (ar_fire && rd_in_range);
  assign ram_o.we    = (wr_accept && wr_tgt == TGT_RAM) ? w_strb_i : '0;
  assign ram_o.idx   = wr_accept ? aw_addr_i[RAM_IDX_W+1:2] : ar_addr_i[RAM_IDX_W+1:2];
  assign ram_o.wdata = w_data_i;

  // ------------------------------------------------------------------------
  // control state
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q     <= 1'b0;
      b_err_q       <= 1'b0;
      ar_ready_q    <= 1'b0;
      rd_busy_q     <= 1'b0;
      r_valid_q     <= 1'b0;
      rd_err_q      <= 1'b0;
      print_valid_q <= 1'b0;
      exit_valid_q  <= 1'b0;
    end else begin
      // write response, held until b_ready
      if (wr_accept) begin
        b_valid_q <= 1'b1;
        b_err_q   <= (wr_tgt == TGT_ERR);
      end else if (b_valid_q && b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      // single cycle pulses, independent of b_ready
      print_valid_q <= wr_accept && (wr_tgt == TGT_PRINT);
      exit_valid_q  <= wr_accept && (wr_tgt == TGT_EXIT_VAL || wr_tgt == TGT_EXIT_ZERO);
      // read side, same flow as the instruction port
      if (ar_fire) begin
        ar_ready_q <= 1'b0;
        rd_busy_q  <= 1'b1;
        rd_err_q   <= !rd_in_range;
      end else if (rd_busy_q) begin
        rd_busy_q <= 1'b0;
        r_valid_q <= 1'b1;
      end else if (r_valid_q && r_ready_i) begin
        r_valid_q  <= 1'b0;
        ar_ready_q <= 1'b1;
      end else if (!r_valid_q) begin
        ar_ready_q <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      print_data_q <= w_data_i[7:0];
      exit_value_q <= (wr_tgt == TGT_EXIT_VAL) ? w_data_i : '0;
    end
    if (rd_busy_q) begin
      r_data_q <= rd_err_q ? '0 : ram_o.rdata;  // port b not retaken until capture
    end
  end

  assign b_valid_o     = b_valid_q;
  assign b_resp_o      = b_err_q ? RESP_SLVERR : RESP_OKAY;
  assign r_valid_o     = r_valid_q;
  assign r_data_o      = r_data_q;
  assign r_resp_o      = rd_err_q ? RESP_SLVERR : RESP_OKAY;
  assign print_valid_o = print_valid_q;
  assign print_data_o  = print_data_q;
  assign exit_valid_o  = exit_valid_q;
  assign exit_value_o  = exit_value_q;

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o));
  a_ctrl_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(print_valid_o && exit_valid_o));

endmodule

//--- axil/axil_instr_ctrl.sv
module axil_instr_ctrl
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  addr_t     ar_addr_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output word_t     r_data_o,
  output axi_resp_e r_resp_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  ram_port_if.ctrl  ram_o
);

  logic  ar_ready_q;  // no response pending
  logic  busy_q;      // ram read in flight, data lands next edge
  logic  r_valid_q;
  logic  err_q;       // address outside ram
  word_t r_data_q;
  logic  ar_fire;
  logic  in_range;

  assign in_range = (ar_addr_i < RAM_BYTES);
  assign ar_fire  = ar_valid_i && ar_ready_q;

  // ram is read on the address handshake edge, write side tied off
  assign ram_o.en    = ar_fire && in_range;
  assign ram_o.we    = '0;
  assign ram_o.idx   = ar_addr_i[RAM_IDX_W+1:2];
  assign ram_o.wdata = '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_ready_q <= 1'b0;
      busy_q     <= 1'b0;
      r_valid_q  <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      if (ar_fire) begin
        ar_ready_q <= 1'b0;      // one read at a time
        busy_q     <= 1'b1;
        err_q      <= !in_range;
      end else if (busy_q) begin
        busy_q    <= 1'b0;
        r_valid_q <= 1'b1;       // rdata valid since the handshake edge
      end else if (r_valid_q && r_ready_i) begin
        r_valid_q  <= 1'b0;
        ar_ready_q <= 1'b1;
      end else if (!r_valid_q) begin
        ar_ready_q <= 1'b1;      // first cycle out of reset
      end
    end
  end

  // capture once, then hold through any stall
  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      r_data_q <= err_q ? '0 : ram_o.rdata;
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = r_data_q;
  assign r_resp_o   = err_q ? RESP_SLVERR : RESP_OKAY;

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o));

endmodule

//--- ram/dp_byte_ram.sv
module dp_byte_ram
  import mem_pkg::*;
(
  input  logic   clk_i,
  ram_port_if.ram port_a_i,  // instruction controller
  ram_port_if.ram port_b_i   // data controller
);

  localparam int LANE_W = $bits(byte_t);  // width of one strobe lane

  word_t mem_q [2**RAM_IDX_W];  // word array, contents undefined at start

  // both ports share one process so the array has a single writer
  // port b is applied last and wins a same-word collision
  always_ff @(posedge clk_i) begin
    if (port_a_i.en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (port_a_i.we[i]) begin
          mem_q[port_a_i.idx][i*LANE_W +: LANE_W] <= port_a_i.wdata[i*LANE_W +: LANE_W];
        end
      end
      port_a_i.rdata <= mem_q[port_a_i.idx];  // read first, old word on write
    end
    if (port_b_i.en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (port_b_i.we[i]) begin
          mem_q[port_b_i.idx][i*LANE_W +: LANE_W] <= port_b_i.wdata[i*LANE_W +: LANE_W];
        end
      end
      port_b_i.rdata <= mem_q[port_b_i.idx];
    end
  end

  // a controller must never enable the ram with an unresolved index
  a_idx_known_a: assert property (@(posedge clk_i)
    port_a_i.en |-> !$isunknown(port_a_i.idx));
  a_idx_known_b: assert property (@(posedge clk_i)
    port_b_i.en |-> !$isunknown(port_b_i.idx));

endmodule

//--- common/ram_port_if.sv
interface ram_port_if
  import mem_pkg::*;
();

  logic     en;     // port enable, read or write
  strb_t    we;     // byte lane write enables
  ram_idx_t idx;    // word index
  word_t    wdata;  // write data
  word_t    rdata;  // registered read data

  // the bus controller side
  modport ctrl (output en, we, idx, wdata, input rdata);

  // the memory side
  modport ram (input en, we, idx, wdata, output rdata);

endinterface

//--- common/mem_pkg.sv
package mem_pkg;

  // ------------------------------------------------------------------------
  // bus and memory widths
  // ------------------------------------------------------------------------
  localparam int ADDR_W    = 32;           // axi address width
  localparam int DATA_W    = 32;           // data word width
  localparam int STRB_W    = DATA_W / 8;   // one strobe bit per byte lane
  localparam int RAM_IDX_W = 10;           // 1024 words of ram

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [STRB_W-1:0]    strb_t;
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;  // word index, address bits 11:2
  typedef logic [7:0]           byte_t;     // printed character

  // ------------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------------
  // ram sits at byte address 0 and covers the whole word index range
  localparam addr_t RAM_BYTES       = addr_t'((1 << RAM_IDX_W) * STRB_W);
  localparam addr_t PRINT_ADDR      = 32'h1000_0000;  // char out, low byte
  localparam addr_t EXIT_VALUE_ADDR = 32'h2000_0004;  // exit with written word
  localparam addr_t EXIT_ZERO_ADDR  = 32'h2000_0010;  // exit with zero

  // ------------------------------------------------------------------------
  // response codes
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,  // normal access
    RESP_SLVERR = 2'b10   // out of range or unsupported access
  } axi_resp_e;

endpackage
